// File: hw/d_cache_pkg.sv
// Data cache package: fixed geometry, core opcodes and controller states
`default_nettype none

package d_cache_pkg;

    // ============================================================
    // Address split
    // ============================================================
    localparam int ADDR_WIDTH      = 14;  // Core byte address
    localparam int WORD_WIDTH      = 32;
    localparam int LINE_WIDTH      = 128; // Four words per line
    localparam int WORDS_PER_LINE  = LINE_WIDTH / WORD_WIDTH;

    localparam int LSB_WORD_OFFSET = 2;   // Bits 1:0 are the byte offset, ignored
    localparam int MSB_WORD_OFFSET = 3;
    localparam int LSB_SET         = 4;
    localparam int MSB_SET         = 9;
    localparam int LSB_TAG         = 10;
    localparam int MSB_TAG         = 13;

    // ============================================================
    // Derived sizes
    // ============================================================
    localparam int SET_WIDTH       = MSB_SET - LSB_SET + 1; // 6
    localparam int NUM_SETS        = 2 ** SET_WIDTH;        // 64
    localparam int TAG_WIDTH       = MSB_TAG - LSB_TAG + 1; // 4

    // Far memory is addressed by whole lines
    localparam int LINE_ADDR_WIDTH = TAG_WIDTH + SET_WIDTH; // 10
    localparam int NUM_LINES       = 2 ** LINE_ADDR_WIDTH;  // 1024

    // Destination register, only carried through to the response
    localparam int REG_ID_WIDTH    = 5;

    // ============================================================
    // Enums
    // ============================================================
    // Core request opcode
    typedef enum logic {
        RD_OP = 1'b0,
        WR_OP = 1'b1
    } t_opcode;

    // Controller states
    typedef enum logic [2:0] {
        S_LOOKUP    = 3'd0, // Idle, tag compare on incoming request
        S_EVICT     = 3'd1, // Victim write-back when dirty
        S_FILL      = 3'd2, // Line read issued to far memory
        S_FILL_WAIT = 3'd3, // Waiting for the line to come back
        S_REPLAY    = 3'd4  // Held request runs as a hit
    } t_cache_state;

endpackage

`default_nettype wire

// File: hw/far_memory.sv
// Far memory: flat line-addressed backing store with registered read data
`timescale 1ns/1ns
`default_nettype none

module far_memory
    import d_cache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    // Request, always accepted
    input  logic                       mem_req_valid,
    input  logic                       mem_req_write,
    input  logic [LINE_ADDR_WIDTH-1:0] mem_req_line_addr,
    input  logic [LINE_WIDTH-1:0]      mem_req_line,
    // Read response, one cycle later
    output logic                       mem_rsp_valid,
    output logic [LINE_WIDTH-1:0]      mem_rsp_line
);

// ============================================================
// Line array
// ============================================================
logic [LINE_WIDTH-1:0] mem [NUM_LINES];

logic wr_en;
logic rd_en;

assign wr_en = mem_req_valid && mem_req_write;
assign rd_en = mem_req_valid && !mem_req_write;

// Whole array starts at zero
always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int i = 0; i < NUM_LINES; i++) begin
            mem[i] <= '0;
        end
    end else if (wr_en) begin
        mem[mem_req_line_addr] <= mem_req_line; // Taken at the edge
    end
end

// ============================================================
// Read response
// ============================================================
always_ff @(posedge clk) begin
    if (!rst_n) begin
        mem_rsp_valid <= 1'b0;
    end else begin
        mem_rsp_valid <= rd_en;
    end
end

always_ff @(posedge clk) begin
    if (rd_en) mem_rsp_line <= mem[mem_req_line_addr]; // Old contents on same-line write
end

endmodule

`default_nettype wire

// File: hw/d_cache_tag_array.sv
// Data cache tag store: per-set tag, valid and dirty with hit compare
`timescale 1ns/1ns
`default_nettype none

module d_cache_tag_array
    import d_cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [ADDR_WIDTH-1:0] active_address,
    input  logic                  install_line,  // Fill done for this set
    input  logic                  set_dirty,     // Write hit on this set
    output logic                  hit,
    output logic                  victim_valid,
    output logic                  victim_dirty,
    output logic [TAG_WIDTH-1:0]  victim_tag
);

// ============================================================
// Storage
// ============================================================
logic [TAG_WIDTH-1:0] tag_mem [NUM_SETS];
logic [NUM_SETS-1:0]  valid_bits;
logic [NUM_SETS-1:0]  dirty_bits;

logic [SET_WIDTH-1:0] set_idx;
logic [TAG_WIDTH-1:0] addr_tag;

assign set_idx  = active_address[MSB_SET:LSB_SET];
assign addr_tag = active_address[MSB_TAG:LSB_TAG];

// Status bits, cleared by reset
always_ff @(posedge clk) begin
    if (!rst_n) begin
        valid_bits <= '0;
        dirty_bits <= '0;
    end else if (install_line) begin
        valid_bits[set_idx] <= 1'b1;
        dirty_bits[set_idx] <= 1'b0; // Fresh copy of far memory
    end else if (set_dirty) begin
        dirty_bits[set_idx] <= 1'b1;
    end
end

// Tags only matter once valid
always_ff @(posedge clk) begin
    if (install_line) tag_mem[set_idx] <= addr_tag;
end

// ============================================================
// Lookup
// ============================================================
assign victim_valid = valid_bits[set_idx];
assign victim_dirty = dirty_bits[set_idx];
assign victim_tag   = tag_mem[set_idx];   // Old owner of the set on a miss
assign hit          = victim_valid && (victim_tag == addr_tag);

endmodule

`default_nettype wire

// File: hw/d_cache_data_array.sv
// Data cache line store: word write, line fill and word select per set
`timescale 1ns/1ns
`default_nettype none

module d_cache_data_array
    import d_cache_pkg::*;
(
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] active_address,
    input  logic                  word_write,   // Write hit
    input  logic                  line_write,   // Fill from far memory
    input  logic [WORD_WIDTH-1:0] wr_word,
    input  logic [LINE_WIDTH-1:0] fill_line,
    output logic [WORD_WIDTH-1:0] rd_word,
    output logic [LINE_WIDTH-1:0] rd_line
);

// ============================================================
// Storage
// ============================================================
logic [LINE_WIDTH-1:0]   line_mem [NUM_SETS];

logic [SET_WIDTH-1:0]    set_idx;
logic [MSB_WORD_OFFSET-LSB_WORD_OFFSET:0] word_off;
logic [WORD_WIDTH-1:0]   line_words [WORDS_PER_LINE];

assign set_idx  = active_address[MSB_SET:LSB_SET];
assign word_off = active_address[MSB_WORD_OFFSET:LSB_WORD_OFFSET];

// Fill wins over a word write, they never coincide anyway
always_ff @(posedge clk) begin
    if (line_write) begin
        line_mem[set_idx] <= fill_line;
    end else if (word_write) begin
        line_mem[set_idx][word_off*WORD_WIDTH +: WORD_WIDTH] <= wr_word;
    end
end

// ============================================================
// Read side
// ============================================================
assign rd_line = line_mem[set_idx]; // Whole line, used on eviction

// Split the active line into words
genvar w;
generate
    for (w = 0; w < WORDS_PER_LINE; w++) begin : g_words
        assign line_words[w] = rd_line[w*WORD_WIDTH +: WORD_WIDTH];
    end
endgenerate

assign rd_word = line_words[word_off]; // Combinational word select

endmodule

`default_nettype wire

// File: hw/d_cache_ctrl.sv
// Data cache controller: hit handling, victim eviction, line fill and replay
`timescale 1ns/1ns
`default_nettype none

module d_cache_ctrl
    import d_cache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    // Core request
    input  logic                       req_valid,
    input  t_opcode                    req_opcode,
    input  logic [ADDR_WIDTH-1:0]      req_address,
    input  logic [WORD_WIDTH-1:0]      req_data,
    input  logic [REG_ID_WIDTH-1:0]    req_reg_id,
    output logic                       busy,
    // Tag array
    input  logic                       hit,
    input  logic                       victim_valid,
    input  logic                       victim_dirty,
    input  logic [TAG_WIDTH-1:0]       victim_tag,
    output logic [ADDR_WIDTH-1:0]      active_address,
    output logic                       install_line,
    output logic                       set_dirty,
    // Data array
    input  logic [WORD_WIDTH-1:0]      rd_word,
    input  logic [LINE_WIDTH-1:0]      rd_line,
    output logic                       word_write,
    output logic                       line_write,
    output logic [WORD_WIDTH-1:0]      wr_word,
    output logic [LINE_WIDTH-1:0]      fill_line,
    // Far memory
    input  logic                       mem_rsp_valid,
    input  logic [LINE_WIDTH-1:0]      mem_rsp_line,
    output logic                       mem_req_valid,
    output logic                       mem_req_write,
    output logic [LINE_ADDR_WIDTH-1:0] mem_req_line_addr,
    output logic [LINE_WIDTH-1:0]      mem_req_line,
    // Core read response
    output logic                       rsp_valid,
    output logic [ADDR_WIDTH-1:0]      rsp_address,
    output logic [REG_ID_WIDTH-1:0]    rsp_reg_id,
    output logic [WORD_WIDTH-1:0]      rsp_data
);

t_cache_state state;
t_cache_state next_state;

// Request parked during a miss
t_opcode                 held_opcode;
logic [ADDR_WIDTH-1:0]   held_address;
logic [WORD_WIDTH-1:0]   held_data;
logic [REG_ID_WIDTH-1:0] held_reg_id;

// Request being served this cycle, new or replayed
logic                    cur_valid;
t_opcode                 cur_opcode;
logic [REG_ID_WIDTH-1:0] cur_reg_id;
logic                    do_read;
logic                    do_write;
logic                    miss;

// ============================================================
// Request select and hit decisions
// ============================================================
always_comb begin
    if (state == S_LOOKUP) begin
        cur_valid      = req_valid;     // Fresh request from the core
        cur_opcode     = req_opcode;
        cur_reg_id     = req_reg_id;
        active_address = req_address;
        wr_word        = req_data;
    end else begin
        cur_valid      = (state == S_REPLAY); // Only replay acts on the held request
        cur_opcode     = held_opcode;
        cur_reg_id     = held_reg_id;
        active_address = held_address;
        wr_word        = held_data;
    end
end

assign do_read    = cur_valid && hit && (cur_opcode == RD_OP);
assign do_write   = cur_valid && hit && (cur_opcode == WR_OP);
assign miss       = (state == S_LOOKUP) && req_valid && !hit;
assign word_write = do_write;
assign set_dirty  = do_write;   // Written line now differs from far memory
assign fill_line  = mem_rsp_line;
assign busy       = (state != S_LOOKUP);

// ============================================================
// Miss sequencing
// ============================================================
always_comb begin
    next_state        = state;
    install_line      = 1'b0;
    line_write        = 1'b0;
    mem_req_valid     = 1'b0;
    mem_req_write     = 1'b0;
    mem_req_line_addr = held_address[MSB_TAG:LSB_SET]; // Fill address by default
    mem_req_line      = rd_line;                        // Victim line for write-back
    case (state)
        S_LOOKUP: begin
            if (miss) next_state = S_EVICT;
        end
        S_EVICT: begin
            // Clean or empty victims are simply dropped
            if (victim_valid && victim_dirty) begin
                mem_req_valid     = 1'b1;
                mem_req_write     = 1'b1;
                mem_req_line_addr = {victim_tag, held_address[MSB_SET:LSB_SET]};
            end
            next_state = S_FILL;
        end
        S_FILL: begin
            mem_req_valid = 1'b1; // Line read
            next_state    = S_FILL_WAIT;
        end
        S_FILL_WAIT: begin
            if (mem_rsp_valid) begin
                install_line = 1'b1; // New tag, valid, clean
                line_write   = 1'b1;
                next_state   = S_REPLAY;
            end
        end
        S_REPLAY: next_state = S_LOOKUP;
        default:  next_state = S_LOOKUP;
    endcase
end

// ============================================================
// Registers
// ============================================================
always_ff @(posedge clk) begin
    if (!rst_n) begin
        state     <= S_LOOKUP;
        rsp_valid <= 1'b0;
    end else begin
        state     <= next_state;
        rsp_valid <= do_read;  // One cycle after the hit
    end
end

always_ff @(posedge clk) begin
    if (miss) begin
        held_opcode  <= req_opcode;
        held_address <= req_address;
        held_data    <= req_data;
        held_reg_id  <= req_reg_id;
    end
    if (do_read) begin
        rsp_address <= active_address;
        rsp_reg_id  <= cur_reg_id;
        rsp_data    <= rd_word;
    end
end

endmodule

`default_nettype wire

// File: hw/d_cache_top.sv
// Data cache top: controller, tag and data arrays and far memory wired to the core
`timescale 1ns/1ns
`default_nettype none

module d_cache_top
    import d_cache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    // Core request
    input  logic                    req_valid,
    input  t_opcode                 req_opcode,
    input  logic [ADDR_WIDTH-1:0]   req_address,
    input  logic [WORD_WIDTH-1:0]   req_data,
    input  logic [REG_ID_WIDTH-1:0] req_reg_id,
    output logic                    busy,
    // Core read response
    output logic                    rsp_valid,
    output logic [ADDR_WIDTH-1:0]   rsp_address,
    output logic [REG_ID_WIDTH-1:0] rsp_reg_id,
    output logic [WORD_WIDTH-1:0]   rsp_data
);

// ============================================================
// Internal nets
// ============================================================
logic [ADDR_WIDTH-1:0]      active_address; // Shared by both arrays
logic                       install_line;
logic                       set_dirty;
logic                       hit;
logic                       victim_valid;
logic                       victim_dirty;
logic [TAG_WIDTH-1:0]       victim_tag;
logic                       word_write;
logic                       line_write;
logic [WORD_WIDTH-1:0]      wr_word;
logic [LINE_WIDTH-1:0]      fill_line;
logic [WORD_WIDTH-1:0]      rd_word;
logic [LINE_WIDTH-1:0]      rd_line;
logic                       mem_req_valid;  // Far memory side
logic                       mem_req_write;
logic [LINE_ADDR_WIDTH-1:0] mem_req_line_addr;
logic [LINE_WIDTH-1:0]      mem_req_line;
logic                       mem_rsp_valid;
logic [LINE_WIDTH-1:0]      mem_rsp_line;

d_cache_ctrl u_ctrl (.*);

d_cache_tag_array u_tag_array (.*);

d_cache_data_array u_data_array (.*);

far_memory u_far_memory (.*);

endmodule

`default_nettype wire

// File: tests/d_cache_clk_gen.sv
// Testbench clock and reset source: 20 ns clock, reset held low for 16 cycles
`timescale 1ns/1ns
`default_nettype none

module d_cache_clk_gen (
    output logic clk,
    output logic rst_n
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
end

initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk); // 16 reset edges
    #2 rst_n = 1'b1;            // Released off the edge, like the stimulus
end

endmodule

`default_nettype wire

// File: tests/d_cache_tb.sv
// Data cache testbench: directed and random requests checked against a shadow memory
`timescale 1ns/1ns
`default_nettype none

module d_cache_tb
    import d_cache_pkg::*;
();

logic                    clk;
logic                    rst_n;
logic                    req_valid;
t_opcode                 req_opcode;
logic [ADDR_WIDTH-1:0]   req_address;
logic [WORD_WIDTH-1:0]   req_data;
logic [REG_ID_WIDTH-1:0] req_reg_id;
logic                    busy;
logic                    rsp_valid;
logic [ADDR_WIDTH-1:0]   rsp_address;
logic [REG_ID_WIDTH-1:0] rsp_reg_id;
logic [WORD_WIDTH-1:0]   rsp_data;

// Every word written so far, keyed by word address
logic [WORD_WIDTH-1:0] shadow [logic [ADDR_WIDTH-LSB_WORD_OFFSET-1:0]];

// Reads in flight, oldest first
logic [ADDR_WIDTH-1:0]   exp_addr_q [$];
logic [REG_ID_WIDTH-1:0] exp_reg_q  [$];
logic [WORD_WIDTH-1:0]   exp_data_q [$];
logic [ADDR_WIDTH-1:0]   chk_addr;
logic [REG_ID_WIDTH-1:0] chk_reg;
logic [WORD_WIDTH-1:0]   chk_data;

logic [REG_ID_WIDTH-1:0] rid_ctr;   // Register ids for directed reads
logic [31:0]             rnd;
logic [ADDR_WIDTH-1:0]   rnd_addr;
int                      rsp_count;
int                      reads_issued;
int                      writes_issued;
int                      wait_cycles;

d_cache_clk_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

d_cache_top dut0 (.*);

// ============================================================
// Helpers
// ============================================================
task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "Stopped at the first error");
endtask

task automatic check_idle_outputs();
    assert (busy === 1'b0) else begin
        $display("** Error at %0t: busy expected 0 actual %b", $time, busy);
        abort_run();
    end
    assert (rsp_valid === 1'b0) else begin
        $display("** Error at %0t: rsp_valid expected 0 actual %b", $time, rsp_valid);
        abort_run();
    end
endtask

// Reference model, zero for words never written
function automatic logic [WORD_WIDTH-1:0] expected_word(input logic [ADDR_WIDTH-1:0] addr);
    logic [ADDR_WIDTH-LSB_WORD_OFFSET-1:0] waddr;
    logic [WORD_WIDTH-1:0]                 value;
    waddr = addr[MSB_TAG:LSB_WORD_OFFSET];
    value = '0;
    if (shadow.exists(waddr)) value = shadow[waddr];
    return value;
endfunction

// Tag, set and word offset into a word-aligned byte address
function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
                                                    input logic [SET_WIDTH-1:0] set,
                                                    input logic [1:0]           word);
    return {tag, set, word, 2'b00};
endfunction

task automatic wait_idle();
    int waited;
    waited = 0;
    while (busy !== 1'b0 && waited < 100) begin
        @(posedge clk);
        #2;
        waited++;
    end
    if (busy !== 1'b0) begin
        $display("Timeout at %0t: busy stayed high for 100 cycles", $time);
        abort_run();
    end
endtask

// One-cycle strobe, driven 2 ns after the edge
task automatic send_request(input t_opcode                 op,
                            input logic [ADDR_WIDTH-1:0]   addr,
                            input logic [WORD_WIDTH-1:0]   data,
                            input logic [REG_ID_WIDTH-1:0] reg_id);
    wait_idle();
    if (op == RD_OP) begin
        exp_addr_q.push_back(addr);
        exp_reg_q.push_back(reg_id);
        exp_data_q.push_back(expected_word(addr));
        reads_issued++;
    end else begin
        shadow[addr[MSB_TAG:LSB_WORD_OFFSET]] = data;
        writes_issued++;
    end
    req_valid   = 1'b1;
    req_opcode  = op;
    req_address = addr;
    req_data    = data;
    req_reg_id  = reg_id;
    @(posedge clk);
    #2;
    req_valid = 1'b0;
endtask

task automatic read_word(input logic [ADDR_WIDTH-1:0] addr);
    send_request(RD_OP, addr, '0, rid_ctr);
    rid_ctr = rid_ctr + 1'b1;
endtask

task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [WORD_WIDTH-1:0] data);
    send_request(WR_OP, addr, data, '0);
endtask

task automatic drain_responses();
    int waited;
    waited = 0;
    while (exp_addr_q.size() != 0 && waited < 100) begin
        @(posedge clk);
        #2;
        waited++;
    end
    if (exp_addr_q.size() != 0) begin
        $display("Timeout at %0t: %0d read responses never arrived", $time, exp_addr_q.size());
        abort_run();
    end
endtask

// ============================================================
// Response checker
// ============================================================
always @(negedge clk) begin
    if (rst_n === 1'b1 && rsp_valid === 1'b1) begin
        if (exp_addr_q.size() == 0) begin
            $display("Read response at %0t with no read outstanding", $time);
            abort_run();
        end else begin
            chk_addr = exp_addr_q.pop_front();
            chk_reg  = exp_reg_q.pop_front();
            chk_data = exp_data_q.pop_front();
            assert (rsp_address === chk_addr) else begin
                $display("** Error at %0t: rsp_address expected %h actual %h",
                         $time, chk_addr, rsp_address);
                abort_run();
            end
            assert (rsp_reg_id === chk_reg) else begin
                $display("** Error at %0t: rsp_reg_id expected %0d actual %0d",
                         $time, chk_reg, rsp_reg_id);
                abort_run();
            end
            assert (rsp_data === chk_data) else begin
                $display("** Error at %0t: rsp_data expected %h actual %h",
                         $time, chk_data, rsp_data);
                abort_run();
            end
            rsp_count++;
        end
    end
end

// ============================================================
// Stimulus
// ============================================================
initial begin
    req_valid     = 1'b0;
    req_opcode    = RD_OP;
    req_address   = '0;
    req_data      = '0;
    req_reg_id    = '0;
    rid_ctr       = '0;
    rsp_count     = 0;
    reads_issued  = 0;
    writes_issued = 0;
    void'($urandom(32'h75bb5e96));

    // Quiet outputs through reset and one cycle past it
    wait_cycles = 0;
    while (rst_n !== 1'b1 && wait_cycles < 40) begin
        @(negedge clk);
        check_idle_outputs();
        wait_cycles++;
    end
    if (rst_n !== 1'b1) begin
        $display("Timeout at %0t: reset never released", $time);
        abort_run();
    end
    @(negedge clk);
    check_idle_outputs();
    @(posedge clk);
    #2;

    // Cold reads in a few sets
    read_word(make_addr(4'd0, 6'd0, 2'd0));
    read_word(make_addr(4'd1, 6'd1, 2'd3));
    read_word(make_addr(4'd7, 6'd17, 2'd1));
    read_word(make_addr(4'd15, 6'd63, 2'd2));

    // Fill one line word by word, reading the whole line each time
    for (int w = 0; w < 4; w++) begin
        write_word(make_addr(4'd2, 6'd9, w[1:0]), 32'h1111_1111 * (w + 1));
        for (int r = 0; r < 4; r++) begin
            read_word(make_addr(4'd2, 6'd9, r[1:0]));
        end
    end

    // Two tags fighting over set 5, two dirty evictions then a clean one
    write_word(make_addr(4'd1, 6'd5, 2'd2), 32'hDEAD_BEEF);
    write_word(make_addr(4'd6, 6'd5, 2'd2), 32'h0BAD_CAFE);
    read_word(make_addr(4'd6, 6'd5, 2'd2));
    read_word(make_addr(4'd1, 6'd5, 2'd2));
    read_word(make_addr(4'd6, 6'd5, 2'd2));
    drain_responses();

    // Second read of a resident line answers one cycle later
    read_word(make_addr(4'd3, 6'd20, 2'd0));
    drain_responses();
    read_word(make_addr(4'd3, 6'd20, 2'd1));
    @(negedge clk);
    assert (rsp_valid === 1'b1) else begin
        $display("** Error at %0t: rsp_valid expected 1 actual %b", $time, rsp_valid);
        abort_run();
    end
    assert (busy === 1'b0) else begin
        $display("** Error at %0t: busy expected 0 actual %b", $time, busy);
        abort_run();
    end
    @(posedge clk);
    #2;

    // Random mix over tags 0 to 3 and every set
    for (int i = 0; i < 400; i++) begin
        rnd      = $urandom();
        rnd_addr = {2'b00, rnd[11:0]};
        if (rnd[31]) begin
            send_request(WR_OP, rnd_addr, $urandom(), rnd[20:16]);
        end else begin
            send_request(RD_OP, rnd_addr, '0, rnd[20:16]);
        end
    end
    drain_responses();

    $display("%0d reads, %0d writes, %0d responses checked",
             reads_issued, writes_issued, rsp_count);
    $display("*** PASSED ***");
    $finish;
end

endmodule

`default_nettype wire

// File: all.f
hw/d_cache_pkg.sv
hw/far_memory.sv
hw/d_cache_tag_array.sv
hw/d_cache_data_array.sv
hw/d_cache_ctrl.sv
hw/d_cache_top.sv
tests/d_cache_clk_gen.sv
tests/d_cache_tb.sv

// File: run.sh
#!/bin/sh
# Build the data cache testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f all.f --top-module d_cache_tb -o d_cache_sim \
    && ./obj_dir/d_cache_sim > sim.log 2>&1

grep -qx '\*\*\* PASSED \*\*\*' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
